// File: common/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

////////////////////////////////////////
// Fetch front end sizing
////////////////////////////////////////

// PC and address width
`define FETCH_ADDR_W 16

// PC bits used to index the history table
// 8 bits gives 256 one-bit entries
`define PRED_IDX_W 8

// ROM index width, PC wraps over the ROM
`define ROM_ADDR_W 8

`endif

// File: common/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

    // Address as seen by fetch and commit
    typedef logic [`FETCH_ADDR_W-1:0] addr_t;

    // Raw 16-bit instruction word
    typedef logic [15:0] instr_t;

    ////////////////////////////////////////
    // Opcode field, bits 15 to 11
    ////////////////////////////////////////

    // Control-flow opcodes only
    // Anything else decodes as an ordinary instruction
    typedef enum logic [4:0] {
        // Unconditional jump, 11-bit offset
        OP_J    = 5'b00010,
        // Taken when zero flag set
        OP_BEQZ = 5'b00100,
        // Taken when zero flag clear
        OP_BNEZ = 5'b00101,
        // Jump to register target
        OP_JR   = 5'b01000
    } opcode_e;

endpackage

// File: ifetch/branch_predictor.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module branch_predictor #(
    parameter int IDX_W = `PRED_IDX_W
) (
    input  logic             CLK,
    input  logic             RST,
    // Lookup side, current fetch PC
    input  logic [IDX_W-1:0] lookup_idx_i,
    // Update side, PC of the word in decode
    input  logic             update_i,
    input  logic [IDX_W-1:0] update_idx_i,
    output logic             predict_o
);

    // Number of history entries
    localparam int ENTRIES = 1 << IDX_W;

    ////////////////////////////////////////
    // History table
    ////////////////////////////////////////

    // One bit per entry
    // Set means predict taken
    logic [ENTRIES-1:0] hist_q;

    // Pending flip for the entry of a resolved word
    logic               upd_q;
    logic [IDX_W-1:0]   upd_idx_q;

    // Combinational lookup
    // Same cycle as the ROM read
    assign predict_o = hist_q[lookup_idx_i];

    // Strobe settles late in the cycle
    // Capture it with its index at the rising edge
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            upd_q     <= 1'b0;
            upd_idx_q <= '0;
        end else begin
            upd_q     <= update_i;
            upd_idx_q <= update_idx_i;
        end
    end

    // Flip on the falling edge that follows
    // Redirected fetch latches its prediction after this
    always_ff @(negedge CLK or negedge RST) begin
        if (!RST) begin
            // All entries start as not taken
            hist_q <= '0;
        end else begin
            if (upd_q) begin
                // Wrong guess, invert the entry
                hist_q[upd_idx_q] <= ~hist_q[upd_idx_q];
            end
        end
    end

    // Aliasing is expected
    // Distinct PCs with equal low bits share one entry

endmodule

// File: ifetch/ifetch.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module ifetch (
    input  logic              CLK,
    input  logic              RST,
    // Freeze PC and latches
    input  logic              stall_i,
    // Register jump from resolver
    input  logic              jr_i,
    input  fetch_pkg::addr_t  jr_target_i,
    // Decoded word is a branch
    input  logic              is_branch_i,
    // Decoded word was mispredicted
    input  logic              mispredict_i,
    // Word read from ROM at pc_o
    input  fetch_pkg::instr_t instr_i,
    output fetch_pkg::addr_t  pc_o,
    output logic              predict_o,
    output logic              fetch_valid_o,
    output fetch_pkg::addr_t  epc_o
);

    // Current PC
    fetch_pkg::addr_t pc_q;

    // Values latched for the word now in decode
    fetch_pkg::addr_t pc_lock_q;
    fetch_pkg::addr_t pc_plus1_lock_q;
    fetch_pkg::addr_t pc_target_lock_q;
    logic             pred_lock_q;

    // Held high for one cycle after reset
    logic             hold_q;

    // Fetch-stage arithmetic
    fetch_pkg::addr_t imm_ext;
    fetch_pkg::addr_t pc_plus1;
    fetch_pkg::addr_t pc_target;
    fetch_pkg::addr_t next_pc;
    logic             pred_now;

    ////////////////////////////////////////
    // Predictor
    ////////////////////////////////////////

    // Lookup by current PC
    // Update by latched PC of the decoded word
    branch_predictor #(
        .IDX_W(`PRED_IDX_W)
    ) i_branch_predictor (
        .CLK          (CLK),
        .RST          (RST),
        .lookup_idx_i (pc_q[`PRED_IDX_W-1:0]),
        .update_i     (mispredict_i),
        .update_idx_i (pc_lock_q[`PRED_IDX_W-1:0]),
        .predict_o    (pred_now)
    );

    ////////////////////////////////////////
    // Immediate and targets
    ////////////////////////////////////////

    // J carries an 11-bit offset
    // Everything else uses the low byte
    always_comb begin
        if (instr_i[15:11] == fetch_pkg::OP_J) begin
            imm_ext = {{(`FETCH_ADDR_W-11){instr_i[10]}}, instr_i[10:0]};
        end else begin
            imm_ext = {{(`FETCH_ADDR_W-8){instr_i[7]}}, instr_i[7:0]};
        end
    end

    // Fall-through and taken target
    assign pc_plus1  = pc_q + fetch_pkg::addr_t'(1);
    assign pc_target = pc_plus1 + imm_ext;

    // Next PC priority
    // Register jump, then recovery, then prediction
    always_comb begin
        if (jr_i) begin
            next_pc = jr_target_i;
        end else if (mispredict_i) begin
            // Predicted taken means fall-through was right
            next_pc = pred_lock_q ? pc_plus1_lock_q : pc_target_lock_q;
        end else begin
            next_pc = pred_now ? pc_target : pc_plus1;
        end
    end

    ////////////////////////////////////////
    // PC and recovery latches
    ////////////////////////////////////////

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            pc_q             <= '0;
            pc_lock_q        <= '0;
            pc_plus1_lock_q  <= '0;
            pc_target_lock_q <= '0;
            pred_lock_q      <= 1'b0;
            hold_q           <= 1'b1;
        end else begin
            if (!stall_i) begin
                if (hold_q) begin
                    // First cycle out of reset, PC stays at 0
                    hold_q <= 1'b0;
                end else begin
                    // Save state of the word heading into decode
                    pc_lock_q        <= pc_q;
                    pc_plus1_lock_q  <= pc_plus1;
                    pc_target_lock_q <= pc_target;
                    pred_lock_q      <= pred_now;
                    pc_q             <= next_pc;
                end
            end
        end
    end

    // Outputs to ROM and resolver
    assign pc_o          = pc_q;
    assign predict_o     = pred_lock_q;
    assign fetch_valid_o = !hold_q;

    // Exception PC
    // Control-flow word in decode reports its own PC
    assign epc_o = (is_branch_i || jr_i) ? pc_lock_q : pc_q;

endmodule

// File: hdl/instr_rom.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module instr_rom (
    input  logic                   CLK,
    // Fetch read port
    input  logic [`ROM_ADDR_W-1:0] addr_i,
    // Load port, driven while RST is low
    input  logic                   load_we_i,
    input  logic [`ROM_ADDR_W-1:0] load_addr_i,
    input  fetch_pkg::instr_t      load_data_i,
    output fetch_pkg::instr_t      data_o
);

    // Word count
    localparam int DEPTH = 1 << `ROM_ADDR_W;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    // Contents come only from the load port
    fetch_pkg::instr_t mem [DEPTH];

    // Synchronous write
    always_ff @(posedge CLK) begin
        if (load_we_i) begin
            mem[load_addr_i] <= load_data_i;
        end
    end

    // Asynchronous read
    // Word is available in the same cycle as the PC
    assign data_o = mem[addr_i];

endmodule

// File: hdl/branch_resolver.sv
`timescale 1ns/1ps

module branch_resolver (
    input  logic              CLK,
    input  logic              RST,
    input  logic              stall_i,
    // Fetch stage word
    input  logic              fetch_valid_i,
    input  fetch_pkg::addr_t  fetch_pc_i,
    input  fetch_pkg::instr_t fetch_instr_i,
    // Prediction made for the word in decode
    input  logic              predict_i,
    // External flag and register target
    input  logic              zero_i,
    input  fetch_pkg::addr_t  jr_target_i,
    // Strobes back to fetch
    output logic              mispredict_o,
    output logic              is_branch_o,
    output logic              jr_o,
    output fetch_pkg::addr_t  jr_target_o,
    // Commit side
    output logic              redirect_o,
    output logic              commit_valid_o,
    output fetch_pkg::addr_t  commit_pc_o,
    output fetch_pkg::instr_t commit_instr_o
);

    // Decode register
    logic              dec_valid_q;
    fetch_pkg::addr_t  dec_pc_q;
    fetch_pkg::instr_t dec_instr_q;

    // Decoded fields
    fetch_pkg::opcode_e dec_op;
    logic               live;
    logic               taken;
    logic               is_cond;

    ////////////////////////////////////////
    // Decode register
    ////////////////////////////////////////

    // Control bit
    // Redirect this cycle kills the word behind it
    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            dec_valid_q <= 1'b0;
        end else begin
            if (!stall_i) begin
                dec_valid_q <= fetch_valid_i && !redirect_o;
            end
        end
    end

    // Payload, no reset
    always_ff @(posedge CLK) begin
        if (!stall_i) begin
            dec_pc_q    <= fetch_pc_i;
            dec_instr_q <= fetch_instr_i;
        end
    end

    ////////////////////////////////////////
    // Outcome
    ////////////////////////////////////////

    assign dec_op = fetch_pkg::opcode_e'(dec_instr_q[15:11]);

    // Word counts only when not frozen
    assign live = dec_valid_q && !stall_i;

    // Real direction of the decoded word
    always_comb begin
        taken   = 1'b0;
        is_cond = 1'b0;
        case (dec_op)
            fetch_pkg::OP_J: begin
                taken   = 1'b1;
                is_cond = 1'b1;
            end
            fetch_pkg::OP_BEQZ: begin
                taken   = zero_i;
                is_cond = 1'b1;
            end
            fetch_pkg::OP_BNEZ: begin
                taken   = !zero_i;
                is_cond = 1'b1;
            end
            default: begin
                // JR and plain words fall through here
                taken   = 1'b0;
                is_cond = 1'b0;
            end
        endcase
    end

    // Strobes
    assign jr_o         = live && (dec_op == fetch_pkg::OP_JR);
    assign is_branch_o  = live && is_cond;
    assign mispredict_o = live && (dec_op != fetch_pkg::OP_JR) && (taken != predict_i);
    assign redirect_o   = mispredict_o || jr_o;
    assign jr_target_o  = jr_target_i;

    // Commit the decoded word
    assign commit_valid_o = live;
    assign commit_pc_o    = dec_pc_q;
    assign commit_instr_o = dec_instr_q;

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_top (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   stall_i,
    // Resolve-time inputs
    input  logic                   zero_i,
    input  fetch_pkg::addr_t       jr_target_i,
    // ROM load port
    input  logic                   load_we_i,
    input  logic [`ROM_ADDR_W-1:0] load_addr_i,
    input  fetch_pkg::instr_t      load_data_i,
    // Commit and status
    output logic                   commit_valid_o,
    output fetch_pkg::addr_t       commit_pc_o,
    output fetch_pkg::instr_t      commit_instr_o,
    output logic                   redirect_o,
    output fetch_pkg::addr_t       epc_o
);

    // Fetch to ROM and resolver
    fetch_pkg::addr_t  pc;
    fetch_pkg::instr_t instr;
    logic              predict;
    logic              fetch_valid;

    // Resolver back to fetch
    logic              mispredict;
    logic              is_branch;
    logic              jr;
    fetch_pkg::addr_t  jr_target;

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////

    ifetch i_ifetch (
        .CLK           (CLK),
        .RST           (RST),
        .stall_i       (stall_i),
        .jr_i          (jr),
        .jr_target_i   (jr_target),
        .is_branch_i   (is_branch),
        .mispredict_i  (mispredict),
        .instr_i       (instr),
        .pc_o          (pc),
        .predict_o     (predict),
        .fetch_valid_o (fetch_valid),
        .epc_o         (epc_o)
    );

    // Low PC bits index the ROM
    instr_rom i_instr_rom (
        .CLK         (CLK),
        .addr_i      (pc[`ROM_ADDR_W-1:0]),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .data_o      (instr)
    );

    ////////////////////////////////////////
    // Resolve and commit
    ////////////////////////////////////////

    branch_resolver i_branch_resolver (
        .CLK            (CLK),
        .RST            (RST),
        .stall_i        (stall_i),
        .fetch_valid_i  (fetch_valid),
        .fetch_pc_i     (pc),
        .fetch_instr_i  (instr),
        .predict_i      (predict),
        .zero_i         (zero_i),
        .jr_target_i    (jr_target_i),
        .mispredict_o   (mispredict),
        .is_branch_o    (is_branch),
        .jr_o           (jr),
        .jr_target_o    (jr_target),
        .redirect_o     (redirect_o),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_instr_o (commit_instr_o)
    );

endmodule

// File: test/tb_fetch_top.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module tb_fetch_top;

    localparam int          HALF_PERIOD  = 50;
    // Sample point, 10 ns ahead of the rising edge
    localparam int          SAMPLE_DELAY = 40;
    localparam int          TIMEOUT      = 5000;
    localparam int          NUM_COMMITS  = 3000;
    localparam int          ROM_DEPTH    = 1 << `ROM_ADDR_W;
    localparam int          HIST_DEPTH   = 1 << `PRED_IDX_W;
    localparam logic [31:0] SEED         = 32'hc38cb49a;

    // DUT inputs
    logic                   CLK;
    logic                   RST;
    logic                   stall_i;
    logic                   zero_i;
    fetch_pkg::addr_t       jr_target_i;
    logic                   load_we_i;
    logic [`ROM_ADDR_W-1:0] load_addr_i;
    fetch_pkg::instr_t      load_data_i;

    // DUT outputs
    logic                   commit_valid_o;
    fetch_pkg::addr_t       commit_pc_o;
    fetch_pkg::instr_t      commit_instr_o;
    logic                   redirect_o;
    fetch_pkg::addr_t       epc_o;

    // Random generator state
    logic [31:0]            rng_state;

    // Reference model state
    fetch_pkg::instr_t      model_rom [ROM_DEPTH];
    logic [HIST_DEPTH-1:0]  model_hist;
    fetch_pkg::addr_t       arch_pc;

    fetch_top i_fetch_top (
        .CLK            (CLK),
        .RST            (RST),
        .stall_i        (stall_i),
        .zero_i         (zero_i),
        .jr_target_i    (jr_target_i),
        .load_we_i      (load_we_i),
        .load_addr_i    (load_addr_i),
        .load_data_i    (load_data_i),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .commit_instr_o (commit_instr_o),
        .redirect_o     (redirect_o),
        .epc_o          (epc_o)
    );

    // 100 ns clock
    always #(HALF_PERIOD) CLK = !CLK;

    ////////////////////////////////////////
    // Random numbers and error reporting
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic step_rng;
        rng_state = xorshift32(rng_state);
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        $display("Test failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic report_failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "Stopped at first error");
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Biased toward control-flow opcodes
    task automatic make_word(output fetch_pkg::instr_t word);
        logic [4:0] op;
        step_rng();
        if (rng_state[3:0] < 4'd3) begin
            op = fetch_pkg::OP_J;
        end else if (rng_state[3:0] < 4'd6) begin
            op = fetch_pkg::OP_BEQZ;
        end else if (rng_state[3:0] < 4'd9) begin
            op = fetch_pkg::OP_BNEZ;
        end else if (rng_state[3:0] < 4'd11) begin
            op = fetch_pkg::OP_JR;
        end else begin
            // Any opcode, mostly plain words
            op = rng_state[8:4];
        end
        word = {op, rng_state[26:16]};
    endtask

    // Stall about 20% of cycles
    task automatic drive_random_inputs;
        step_rng();
        stall_i     = (rng_state[7:0] < 8'd51);
        zero_i      = rng_state[8];
        jr_target_i = rng_state[31:16];
    endtask

    // One cycle per pass, bounded by TIMEOUT
    task automatic wait_for_commit;
        int  idle_cycles;
        logic got_commit;
        idle_cycles = 0;
        got_commit  = 1'b0;
        while (!got_commit) begin
            @(negedge CLK);
            drive_random_inputs();
            #(SAMPLE_DELAY);
            assert (!(stall_i && commit_valid_o))
            else report_failure("commit_valid_o is high while stall_i is high");
            if (commit_valid_o) begin
                got_commit = 1'b1;
            end else begin
                idle_cycles = idle_cycles + 1;
                if (idle_cycles >= TIMEOUT) begin
                    report_failure("no commit seen within the timeout of 5000 cycles");
                end
            end
        end
    endtask

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    // J takes 11 offset bits, all others take 8
    function automatic fetch_pkg::addr_t branch_offset(input fetch_pkg::instr_t word);
        if (word[15:11] == fetch_pkg::OP_J) begin
            return {{5{word[10]}}, word[10:0]};
        end
        return {{8{word[7]}}, word[7:0]};
    endfunction

    task automatic check_commit;
        fetch_pkg::instr_t      exp_instr;
        logic [4:0]             op;
        logic [`PRED_IDX_W-1:0] idx;
        logic                   taken;
        logic                   is_jr;
        logic                   is_ctl;
        logic                   exp_mispredict;
        logic                   exp_redirect;
        fetch_pkg::addr_t       target;
        fetch_pkg::addr_t       next_pc;
        exp_instr = model_rom[arch_pc[`ROM_ADDR_W-1:0]];
        idx       = arch_pc[`PRED_IDX_W-1:0];
        op        = exp_instr[15:11];
        taken     = 1'b0;
        is_jr     = 1'b0;
        is_ctl    = 1'b0;

        // Architectural PC sequence and ROM contents
        assert (commit_pc_o === arch_pc)
        else report_mismatch("commit_pc_o", commit_pc_o, arch_pc);
        assert (commit_instr_o === exp_instr)
        else report_mismatch("commit_instr_o", commit_instr_o, exp_instr);

        // Real outcome from this cycle's flag
        if (op == fetch_pkg::OP_J) begin
            taken  = 1'b1;
            is_ctl = 1'b1;
        end else if (op == fetch_pkg::OP_BEQZ) begin
            taken  = zero_i;
            is_ctl = 1'b1;
        end else if (op == fetch_pkg::OP_BNEZ) begin
            taken  = !zero_i;
            is_ctl = 1'b1;
        end else if (op == fetch_pkg::OP_JR) begin
            is_jr = 1'b1;
        end

        target = arch_pc + 16'd1 + branch_offset(exp_instr);
        if (is_jr) begin
            next_pc = jr_target_i;
        end else if (taken) begin
            next_pc = target;
        end else begin
            next_pc = arch_pc + 16'd1;
        end

        // One-bit history, flips on a wrong guess
        exp_mispredict = !is_jr && (taken != model_hist[idx]);
        if (exp_mispredict) begin
            model_hist[idx] = !model_hist[idx];
        end
        exp_redirect = exp_mispredict || is_jr;
        assert (redirect_o === exp_redirect)
        else report_mismatch("redirect_o", {15'd0, redirect_o}, {15'd0, exp_redirect});

        // Control-flow words report their own PC
        if (is_ctl || is_jr) begin
            assert (epc_o === arch_pc)
            else report_mismatch("epc_o", epc_o, arch_pc);
        end

        arch_pc = next_pc;
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        fetch_pkg::instr_t word;
        CLK         = 1'b0;
        RST         = 1'b0;
        stall_i     = 1'b0;
        zero_i      = 1'b0;
        jr_target_i = '0;
        load_we_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        rng_state   = SEED;
        model_hist  = '0;
        arch_pc     = '0;

        // Program load while reset is held
        for (int i = 0; i < ROM_DEPTH; i++) begin
            @(negedge CLK);
            make_word(word);
            load_we_i    = 1'b1;
            load_addr_i  = i[`ROM_ADDR_W-1:0];
            load_data_i  = word;
            model_rom[i] = word;
        end
        @(negedge CLK);
        load_we_i = 1'b0;

        // Three more reset cycles, release on a falling edge
        repeat (3) @(negedge CLK);
        RST = 1'b1;

        // First commit must come from PC 0
        for (int n = 0; n < NUM_COMMITS; n++) begin
            wait_for_commit();
            check_commit();
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: fetch_top.f
+incdir+common
common/fetch_pkg.sv
ifetch/branch_predictor.sv
ifetch/ifetch.sv
hdl/instr_rom.sv
hdl/branch_resolver.sv
hdl/fetch_top.sv
test/tb_fetch_top.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_fetch_top \
    -Mdir obj_dir \
    -f fetch_top.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_fetch_top > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Test failed" "$SIM_LOG"; then
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

exit 0
